// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PeriodNs    = 8,
  parameter int ResetCycles = 4
) (
  input  wire logic rst_req_i,
  output logic      clk_o,
  output logic      rst_no
);

  // Free-running clock
  initial clk_o = 1'b0;
  always #(PeriodNs / 2) clk_o = ~clk_o;

  // Power-on reset, then re-applied whenever a request is seen on an edge
  initial begin : p_rst
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
    forever begin
      @(posedge clk_o);
      if (rst_req_i) begin
        rst_no <= 1'b0;
        repeat (ResetCycles) @(posedge clk_o);
        rst_no <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_otp_lc_prog.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_otp_lc_prog;
  import otp_lc_pkg::*;

  localparam int ClkPeriodNs = 8;
  localparam int NumRows     = 9;
  localparam int AckTimeout  = 40;
  localparam int BlockWindow = 24;
  localparam int IdleTimeout = 8;
  // Budget of 100 cycles per table row
  localparam int WatchdogNs  = NumRows * 100 * ClkPeriodNs;

  typedef enum logic [1:0] {
    DataFixed,
    DataRandom,
    DataGrow
  } data_mode_e;

  typedef struct packed {
    logic                   do_reset;
    lc_tx_e                 esc;
    logic [LcDataWidth-1:0] data;
    logic                   exp_ack;
    logic                   exp_err;
  } row_t;

  logic clk, rst_n, rst_req;

  // DUT inputs
  logic                   lci_en;
  lc_tx_e                 escalate_en;
  logic                   lc_req;
  logic [LcDataWidth-1:0] lc_data;

  // DUT outputs
  logic     lc_ack, lc_err, fsm_err, prog_idle;
  otp_err_e error;

  row_t rows [NumRows];
  int   num_rows;
  int   err_cnt, check_cnt;

  // Fuse shadow, one entry per life cycle word
  logic [OtpWidth-1:0] shadow [NumLcWords];
  logic                locked;
  otp_err_e            locked_err;

  tb_clk_gen #(.PeriodNs(ClkPeriodNs), .ResetCycles(4)) i_clk_gen (
    .rst_req_i(rst_req), .clk_o(clk), .rst_no(rst_n)
  );

  otp_lc_prog_top i_dut (
    .clk_i(clk), .rst_ni(rst_n), .lci_en_i(lci_en), .escalate_en_i(escalate_en),
    .lc_req_i(lc_req), .lc_data_i(lc_data), .lc_ack_o(lc_ack), .lc_err_o(lc_err),
    .error_o(error), .fsm_err_o(fsm_err), .lci_prog_idle_o(prog_idle)
  );

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH %0t %s: got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_err(input string name, input otp_err_e got, input otp_err_e exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH %0t %s: got %s (%0d) expected %s (%0d)", $time, name,
               got.name(), got, exp.name(), exp);
    end
  endtask

  ////////////////////////////////////////
  // Fuse shadow model
  ////////////////////////////////////////

  task automatic clear_shadow();
    for (int w = 0; w < NumLcWords; w++) begin
      shadow[w] = '0;
    end
  endtask

  // A word fails when it would clear a burnt bit
  function automatic logic predict_fail(input logic [LcDataWidth-1:0] data);
    logic fail;
    fail = 1'b0;
    for (int w = 0; w < NumLcWords; w++) begin
      if ((shadow[w] & ~data[w*OtpWidth +: OtpWidth]) != '0) begin
        fail = 1'b1;
      end
    end
    return fail;
  endfunction

  // Every word that passes its own check gets burnt
  task automatic commit_shadow(input logic [LcDataWidth-1:0] data);
    for (int w = 0; w < NumLcWords; w++) begin
      if ((shadow[w] & ~data[w*OtpWidth +: OtpWidth]) == '0) begin
        shadow[w] = shadow[w] | data[w*OtpWidth +: OtpWidth];
      end
    end
  endtask

  ////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////

  function automatic logic [LcDataWidth-1:0] random_state();
    logic [LcDataWidth-1:0] val;
    for (int i = 0; i < LcDataWidth / 32; i++) begin
      val[i*32 +: 32] = $urandom();
    end
    return val;
  endfunction

  task automatic add_row(input logic do_reset, input lc_tx_e esc, input data_mode_e mode,
                         input logic [LcDataWidth-1:0] fixed, input logic exp_ack,
                         input logic exp_err);
    row_t row;
    row.do_reset = do_reset;
    row.esc      = esc;
    row.exp_ack  = exp_ack;
    row.exp_err  = exp_err;
    case (mode)
      DataRandom: row.data = random_state();
      // Superset of the previous row
      DataGrow:   row.data = rows[num_rows-1].data | random_state();
      default:    row.data = fixed;
    endcase
    rows[num_rows] = row;
    num_rows++;
  endtask

  task automatic build_table();
    int unsigned seed;
    seed     = 32'hc962;
    void'($urandom(seed));
    num_rows = 0;
    // Blank fuses, then a superset, then a clearing write and a blocked request
    add_row(1'b1, LcTxOff, DataRandom, '0, 1'b1, 1'b0);
    add_row(1'b0, LcTxOff, DataGrow, '0, 1'b1, 1'b0);
    add_row(1'b0, LcTxOff, DataFixed, '0, 1'b1, 1'b1);
    add_row(1'b0, LcTxOff, DataFixed, '1, 1'b0, 1'b0);
    // Fixed patterns after a fresh reset
    add_row(1'b1, LcTxOff, DataFixed, {NumLcWords{16'h0f0f}}, 1'b1, 1'b0);
    add_row(1'b0, LcTxOff, DataFixed, {NumLcWords{16'h3f3f}}, 1'b1, 1'b0);
    add_row(1'b0, LcTxOff, DataFixed, {NumLcWords{16'h0303}}, 1'b1, 1'b1);
    // Escalation locks the interface
    add_row(1'b1, LcTxOn, DataRandom, '0, 1'b0, 1'b0);
    add_row(1'b0, LcTxOff, DataRandom, '0, 1'b0, 1'b0);
  endtask

  ////////////////////////////////////////
  // Sequences
  ////////////////////////////////////////

  // Reset, probe the disabled interface, then enable it
  task automatic reset_and_enable();
    logic seen_ack;
    logic seen_idle;
    int   cycles;
    seen_ack  = 1'b0;
    seen_idle = 1'b0;
    cycles    = 0;
    @(posedge clk);
    lci_en      <= 1'b0;
    lc_req      <= 1'b0;
    escalate_en <= LcTxOff;
    rst_req     <= 1'b1;
    @(posedge clk);
    rst_req <= 1'b0;
    @(posedge rst_n);
    @(posedge clk);
    lc_req <= 1'b1;
    // Window is longer than a full transition
    repeat (BlockWindow) begin
      @(negedge clk);
      seen_ack  = seen_ack | lc_ack;
      seen_idle = seen_idle | prog_idle;
    end
    check_bit("lc_ack_o before enable", seen_ack, 1'b0);
    check_bit("lci_prog_idle_o before enable", seen_idle, 1'b0);
    @(posedge clk);
    lc_req <= 1'b0;
    lci_en <= 1'b1;
    do begin
      @(negedge clk);
      cycles++;
    end while (!prog_idle && cycles < IdleTimeout);
    if (!prog_idle) begin
      err_cnt++;
      $display("lci_prog_idle_o did not rise after lci_en_i was set");
    end
    check_err("error_o", error, NoError);
    check_bit("fsm_err_o", fsm_err, 1'b0);
  endtask

  task automatic apply_escalation(input otp_err_e exp_code);
    @(posedge clk);
    escalate_en <= LcTxOn;
    @(negedge clk);
    check_bit("fsm_err_o", fsm_err, 1'b1);
    @(posedge clk);
    escalate_en <= LcTxOff;
    @(negedge clk);
    check_bit("fsm_err_o", fsm_err, 1'b0);
    check_err("error_o", error, exp_code);
    check_bit("lci_prog_idle_o", prog_idle, 1'b0);
  endtask

  // Full transition, the ack is awaited with a timeout
  task automatic program_state(input logic [LcDataWidth-1:0] data, input logic exp_fail);
    logic acked;
    logic err_at_ack;
    int   cycles;
    acked      = 1'b0;
    err_at_ack = 1'b0;
    cycles     = 0;
    @(posedge clk);
    lc_data <= data;
    lc_req  <= 1'b1;
    @(posedge clk);
    lc_req <= 1'b0;
    while (!acked && cycles < AckTimeout) begin
      @(negedge clk);
      cycles++;
      if (lc_ack) begin
        acked      = 1'b1;
        err_at_ack = lc_err;
      end
    end
    if (!acked) begin
      err_cnt++;
      $display("transition was not acknowledged within %0d cycles", AckTimeout);
    end else begin
      check_bit("lc_err_o", err_at_ack, exp_fail);
      // Ack is a single-cycle pulse
      @(negedge clk);
      check_bit("lc_ack_o", lc_ack, 1'b0);
      check_bit("lci_prog_idle_o", prog_idle, !exp_fail);
      check_err("error_o", error, exp_fail ? MacroWriteBlankError : NoError);
      check_bit("fsm_err_o", fsm_err, 1'b0);
    end
  endtask

  // Request on a locked interface, no ack may follow
  task automatic request_blocked(input logic [LcDataWidth-1:0] data);
    logic seen_ack;
    logic seen_idle;
    seen_ack  = 1'b0;
    seen_idle = 1'b0;
    @(posedge clk);
    lc_data <= data;
    lc_req  <= 1'b1;
    repeat (BlockWindow) begin
      @(negedge clk);
      seen_ack  = seen_ack | lc_ack;
      seen_idle = seen_idle | prog_idle;
    end
    @(posedge clk);
    lc_req <= 1'b0;
    check_bit("lc_ack_o while locked", seen_ack, 1'b0);
    check_bit("lci_prog_idle_o while locked", seen_idle, 1'b0);
    check_err("error_o", error, locked_err);
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin : p_main
    row_t cur;
    logic exp_ack;
    logic exp_fail;
    int   err_before;
    lci_en      = 1'b0;
    escalate_en = LcTxOff;
    lc_req      = 1'b0;
    lc_data     = '0;
    rst_req     = 1'b0;
    err_cnt     = 0;
    check_cnt   = 0;
    locked      = 1'b0;
    locked_err  = NoError;
    clear_shadow();
    build_table();
    @(posedge rst_n);
    for (int r = 0; r < NumRows; r++) begin
      cur        = rows[r];
      err_before = err_cnt;
      if (cur.do_reset) begin
        reset_and_enable();
        clear_shadow();
        locked     = 1'b0;
        locked_err = NoError;
      end
      // Outcome predicted from the lock state and the shadow
      exp_ack  = !locked && (cur.esc == LcTxOff);
      exp_fail = exp_ack && predict_fail(cur.data);
      if (exp_ack !== cur.exp_ack || exp_fail !== cur.exp_err) begin
        err_cnt++;
        $display("table row %0d does not agree with the fuse model", r);
      end
      if (cur.esc != LcTxOff) begin
        if (!locked) begin
          locked_err = FsmStateError;
        end
        locked = 1'b1;
        apply_escalation(locked_err);
      end
      if (exp_ack) begin
        program_state(cur.data, exp_fail);
        commit_shadow(cur.data);
        if (exp_fail) begin
          locked     = 1'b1;
          locked_err = MacroWriteBlankError;
        end
      end else begin
        request_blocked(cur.data);
      end
      $display("row %0d: %s (%0d errors)", r, (err_cnt == err_before) ? "ok" : "bad",
               err_cnt - err_before);
    end
    $display("rows %0d, checks %0d, errors %0d", NumRows, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin : p_watchdog
    #(WatchdogNs);
    $display("watchdog expired at %0t, run exceeded its cycle budget", $time);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
src/otp_lc_pkg.sv
src/otp_lci.sv
src/otp_cmd_router.sv
src/otp_bank.sv
src/otp_rsp_merge.sv
src/otp_lc_prog_top.sv
dv/tb_clk_gen.sv
dv/tb_otp_lc_prog.sv

// ==== src/otp_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module otp_bank (
  input  wire logic                                clk_i,
  input  wire logic                                rst_ni,
  input  wire logic                                cmd_valid_i,
  input  wire logic [otp_lc_pkg::BankRowWidth-1:0] cmd_row_i,
  input  wire logic [otp_lc_pkg::OtpWidth-1:0]     cmd_wdata_i,
  output logic                                     rsp_valid_o,
  output logic                                     rsp_err_o,
  output logic                                     credit_return_o
);
  import otp_lc_pkg::*;

  // Fuse array, blank after reset
  logic [OtpWidth-1:0] fuse_q [BankDepth];

  // Stage one holds the command and the stored word
  logic                    s1_valid_q;
  logic [BankRowWidth-1:0] s1_row_q;
  logic [OtpWidth-1:0]     s1_wdata_q;
  logic [OtpWidth-1:0]     s1_rdata_q;
  logic [OtpWidth-1:0]     s1_rdata_d;

  // Stage two result
  logic                blank_err;
  logic                wr_en;
  logic [OtpWidth-1:0] new_word;

  ////////////////////////////////////////
  // Blank check and program
  ////////////////////////////////////////

  // A zero in the data over a burnt fuse cannot be programmed
  assign blank_err = |(s1_rdata_q & ~s1_wdata_q);
  assign wr_en     = s1_valid_q && !blank_err;
  assign new_word  = s1_rdata_q | s1_wdata_q;

  // Forward the word being burnt to a read of the same row
  always_comb begin : p_read
    s1_rdata_d = fuse_q[cmd_row_i];
    if (wr_en && (s1_row_q == cmd_row_i)) begin
      s1_rdata_d = new_word;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_fuse
    if (!rst_ni) begin
      for (int r = 0; r < BankDepth; r++) begin
        fuse_q[r] <= '0;
      end
    end else if (wr_en) begin
      fuse_q[s1_row_q] <= new_word;
    end
  end

  ////////////////////////////////////////
  // Pipeline
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      s1_valid_q  <= 1'b0;
      rsp_valid_o <= 1'b0;
      rsp_err_o   <= 1'b0;
    end else begin
      s1_valid_q  <= cmd_valid_i;
      rsp_valid_o <= s1_valid_q;
      rsp_err_o   <= s1_valid_q && blank_err;
    end
  end

  always_ff @(posedge clk_i) begin : p_s1_data
    if (cmd_valid_i) begin
      s1_row_q   <= cmd_row_i;
      s1_wdata_q <= cmd_wdata_i;
      s1_rdata_q <= s1_rdata_d;
    end
  end

  // Slot is free again once the response leaves
  assign credit_return_o = rsp_valid_o;

endmodule

`default_nettype wire

// ==== src/otp_cmd_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module otp_cmd_router (
  input  wire logic                                clk_i,
  input  wire logic                                rst_ni,
  input  wire logic                                otp_req_i,
  input  wire logic [otp_lc_pkg::OtpAddrWidth-1:0] otp_addr_i,
  input  wire logic [otp_lc_pkg::OtpWidth-1:0]     otp_wdata_i,
  input  wire logic [otp_lc_pkg::NumBanks-1:0]     credit_return_i,
  output logic                                     otp_gnt_o,
  output logic [otp_lc_pkg::NumBanks-1:0]          cmd_valid_o,
  output logic [otp_lc_pkg::BankRowWidth-1:0]      cmd_row_o,
  output logic [otp_lc_pkg::OtpWidth-1:0]          cmd_wdata_o,
  output logic                                     ord_push_o,
  output logic [otp_lc_pkg::BankIdxWidth-1:0]      ord_bank_o
);
  import otp_lc_pkg::*;

  logic [BankIdxWidth-1:0] bank;
  logic [BankRowWidth-1:0] row;
  logic [CreditWidth-1:0]  credit_d [NumBanks];
  logic [CreditWidth-1:0]  credit_q [NumBanks];
  logic [NumBanks-1:0]     cmd_valid_d;

  // Low address bits pick the bank, the rest is the row
  assign bank = otp_addr_i[BankIdxWidth-1:0];
  assign row  = otp_addr_i[OtpAddrWidth-1:BankIdxWidth];

  // Grant only while the target bank has a free slot
  assign otp_gnt_o = otp_req_i && (credit_q[bank] != '0);

  // Order tag goes to the merger in grant order
  assign ord_push_o = otp_gnt_o;
  assign ord_bank_o = bank;

  ////////////////////////////////////////
  // Credit accounting
  ////////////////////////////////////////

  always_comb begin : p_credit
    cmd_valid_d = '0;
    for (int b = 0; b < NumBanks; b++) begin
      cmd_valid_d[b] = otp_gnt_o && (bank == BankIdxWidth'(b));
      credit_d[b]    = credit_q[b] - CreditWidth'(cmd_valid_d[b])
                     + CreditWidth'(credit_return_i[b]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      cmd_valid_o <= '0;
      for (int b = 0; b < NumBanks; b++) begin
        credit_q[b] <= CreditWidth'(BankCredits);
      end
    end else begin
      cmd_valid_o <= cmd_valid_d;
      credit_q    <= credit_d;
    end
  end

  // Command payload, shared by all banks
  always_ff @(posedge clk_i) begin : p_payload
    if (otp_gnt_o) begin
      cmd_row_o   <= row;
      cmd_wdata_o <= otp_wdata_i;
    end
  end

  // Returned credits never exceed the slots of a bank
  for (genvar b = 0; b < NumBanks; b++) begin : g_chk
    a_credit_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
      credit_q[b] <= CreditWidth'(BankCredits));
  end

endmodule

`default_nettype wire

// ==== src/otp_lc_pkg.sv ====
`default_nettype none

package otp_lc_pkg;

  ////////////////////////////////////////
  // Word and state geometry
  ////////////////////////////////////////

  // Native OTP word
  localparam int OtpWidth     = 16;
  localparam int OtpAddrWidth = 3;

  // Life cycle state is split into native words
  localparam int NumLcWords  = 8;
  localparam int LcDataWidth = NumLcWords * OtpWidth;

  // Word counter must also hold the final count
  localparam int LciCntWidth = 4;
  localparam logic [LciCntWidth-1:0] LastLcWord = LciCntWidth'(NumLcWords - 1);

  ////////////////////////////////////////
  // Bank array
  ////////////////////////////////////////

  // Interleaved banks, low address bit selects the bank
  localparam int NumBanks     = 2;
  localparam int BankIdxWidth = 1;
  localparam int BankDepth    = 4;
  localparam int BankRowWidth = 2;

  // Command slots per bank
  localparam int BankCredits = 2;
  localparam int CreditWidth = 2;

  // Response order tracking
  localparam int OrderDepth    = 4;
  localparam int OrderPtrWidth = 2;

  ////////////////////////////////////////
  // Enums
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    NoError              = 3'h0,
    MacroWriteBlankError = 3'h1,
    MacroOrderError      = 3'h2,
    FsmStateError        = 3'h3
  } otp_err_e;

  typedef enum logic {
    OtpRead  = 1'b0,
    OtpWrite = 1'b1
  } otp_cmd_e;

  // Multi-bit escalation, anything but Off counts as asserted
  typedef enum logic [3:0] {
    LcTxOn  = 4'b0101,
    LcTxOff = 4'b1010
  } lc_tx_e;

  // Sparse encoding, minimum Hamming distance 5
  typedef enum logic [8:0] {
    ResetSt     = 9'b000101011,
    IdleSt      = 9'b110011110,
    WriteSt     = 9'b101010001,
    WriteWaitSt = 9'b010000000,
    ErrorSt     = 9'b011111101
  } lci_state_e;

endpackage

`default_nettype wire

// ==== src/otp_lc_prog_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module otp_lc_prog_top (
  input  wire logic                               clk_i,
  input  wire logic                               rst_ni,
  input  wire logic                               lci_en_i,
  input  wire otp_lc_pkg::lc_tx_e                 escalate_en_i,
  input  wire logic                               lc_req_i,
  input  wire logic [otp_lc_pkg::LcDataWidth-1:0] lc_data_i,
  output logic                                    lc_ack_o,
  output logic                                    lc_err_o,
  output otp_lc_pkg::otp_err_e                    error_o,
  output logic                                    fsm_err_o,
  output logic                                    lci_prog_idle_o
);
  import otp_lc_pkg::*;

  // Interface to router
  logic                    otp_req, otp_gnt, wr_req;
  otp_cmd_e                otp_cmd;
  logic [OtpAddrWidth-1:0] otp_addr;
  logic [OtpWidth-1:0]     otp_wdata;

  // Router to banks
  logic [NumBanks-1:0]     cmd_valid, credit_return;
  logic [BankRowWidth-1:0] cmd_row;
  logic [OtpWidth-1:0]     cmd_wdata;

  // Banks and router to merger
  logic [NumBanks-1:0]     rsp_valid, rsp_err;
  logic                    ord_push;
  logic [BankIdxWidth-1:0] ord_bank;
  logic                    otp_rvalid;
  otp_err_e                otp_err;

  otp_lci u_lci (
    .clk_i, .rst_ni, .lci_en_i, .escalate_en_i, .lc_req_i, .lc_data_i,
    .lc_ack_o, .lc_err_o, .error_o, .fsm_err_o, .lci_prog_idle_o,
    .otp_req_o(otp_req), .otp_cmd_o(otp_cmd), .otp_addr_o(otp_addr),
    .otp_wdata_o(otp_wdata), .otp_gnt_i(otp_gnt),
    .otp_rvalid_i(otp_rvalid), .otp_err_i(otp_err)
  );

  // Only writes are routed to the banks
  assign wr_req = otp_req && (otp_cmd == OtpWrite);

  otp_cmd_router u_router (
    .clk_i, .rst_ni,
    .otp_req_i(wr_req), .otp_addr_i(otp_addr), .otp_wdata_i(otp_wdata),
    .credit_return_i(credit_return), .otp_gnt_o(otp_gnt),
    .cmd_valid_o(cmd_valid), .cmd_row_o(cmd_row), .cmd_wdata_o(cmd_wdata),
    .ord_push_o(ord_push), .ord_bank_o(ord_bank)
  );

  for (genvar b = 0; b < NumBanks; b++) begin : g_bank
    otp_bank u_bank (
      .clk_i, .rst_ni,
      .cmd_valid_i(cmd_valid[b]), .cmd_row_i(cmd_row), .cmd_wdata_i(cmd_wdata),
      .rsp_valid_o(rsp_valid[b]), .rsp_err_o(rsp_err[b]),
      .credit_return_o(credit_return[b])
    );
  end

  otp_rsp_merge u_merge (
    .clk_i, .rst_ni, .ord_push_i(ord_push), .ord_bank_i(ord_bank),
    .rsp_valid_i(rsp_valid), .rsp_err_i(rsp_err),
    .otp_rvalid_o(otp_rvalid), .otp_err_o(otp_err)
  );

endmodule

`default_nettype wire

// ==== src/otp_lci.sv ====
`timescale 1ns/1ps
`default_nettype none

module otp_lci (
  input  wire logic                               clk_i,
  input  wire logic                               rst_ni,
  input  wire logic                               lci_en_i,
  input  wire otp_lc_pkg::lc_tx_e                 escalate_en_i,
  // Transition request from the life cycle controller
  input  wire logic                               lc_req_i,
  input  wire logic [otp_lc_pkg::LcDataWidth-1:0] lc_data_i,
  output logic                                    lc_ack_o,
  output logic                                    lc_err_o,
  output otp_lc_pkg::otp_err_e                    error_o,
  output logic                                    fsm_err_o,
  output logic                                    lci_prog_idle_o,
  // Write command side
  output logic                                    otp_req_o,
  output otp_lc_pkg::otp_cmd_e                    otp_cmd_o,
  output logic [otp_lc_pkg::OtpAddrWidth-1:0]     otp_addr_o,
  output logic [otp_lc_pkg::OtpWidth-1:0]         otp_wdata_o,
  input  wire logic                               otp_gnt_i,
  // Merged responses, in issue order
  input  wire logic                               otp_rvalid_i,
  input  wire otp_lc_pkg::otp_err_e               otp_err_i
);
  import otp_lc_pkg::*;

  lci_state_e state_d, state_q;
  otp_err_e   error_d, error_q;

  // Issue and response counters, each with a shadow copy
  logic [LciCntWidth-1:0] iss_q, iss_dup_q;
  logic [LciCntWidth-1:0] rsp_q, rsp_dup_q;
  logic cnt_clr, iss_inc, rsp_inc, cnt_err;
  logic esc_en;

  logic [NumLcWords-1:0][OtpWidth-1:0] data;

  assign data    = lc_data_i;
  assign error_o = error_q;
  assign esc_en  = (escalate_en_i != LcTxOff);

  // Any divergence of a shadow counter is treated as a fault
  assign cnt_err = (iss_q != iss_dup_q) || (rsp_q != rsp_dup_q);

  ////////////////////////////////////////
  // Controller FSM
  ////////////////////////////////////////

  always_comb begin : p_fsm
    state_d         = state_q;
    error_d         = error_q;
    cnt_clr         = 1'b0;
    iss_inc         = 1'b0;
    rsp_inc         = 1'b0;
    lci_prog_idle_o = 1'b0;
    otp_req_o       = 1'b0;
    otp_cmd_o       = OtpRead;
    lc_ack_o        = 1'b0;
    lc_err_o        = 1'b0;
    fsm_err_o       = 1'b0;

    case (state_q)
      // Wait for the enable after reset
      ResetSt: begin
        if (lci_en_i) begin
          state_d = IdleSt;
        end
      end
      IdleSt: begin
        lci_prog_idle_o = 1'b1;
        if (lc_req_i) begin
          state_d = WriteSt;
          cnt_clr = 1'b1;
        end
      end
      // Issue words back to back, responses may already return here
      WriteSt: begin
        otp_req_o = 1'b1;
        otp_cmd_o = OtpWrite;
        if (otp_gnt_i) begin
          iss_inc = 1'b1;
          if (iss_q == LastLcWord) begin
            state_d = WriteWaitSt;
          end
        end
        if (otp_rvalid_i) begin
          rsp_inc = 1'b1;
          // Keep only the first error code
          if (otp_err_i != NoError && error_q == NoError) begin
            error_d = otp_err_i;
          end
        end
      end
      // Drain remaining responses, all words are programmed even after an error
      WriteWaitSt: begin
        if (otp_rvalid_i) begin
          rsp_inc = 1'b1;
          if (otp_err_i != NoError && error_q == NoError) begin
            error_d = otp_err_i;
          end
          if (rsp_q == LastLcWord) begin
            lc_ack_o = 1'b1;
            state_d  = IdleSt;
            if (error_d != NoError) begin
              lc_err_o = 1'b1;
              state_d  = ErrorSt;
            end
          end
        end
      end
      // Terminal, never left without reset
      ErrorSt: begin
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
      end
      // Glitched into an undefined encoding
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation and counter faults override everything
    if (esc_en || cnt_err) begin
      state_d   = ErrorSt;
      fsm_err_o = 1'b1;
      if (error_q == NoError) begin
        error_d = FsmStateError;
      end
    end
  end

  ////////////////////////////////////////
  // Command outputs
  ////////////////////////////////////////

  // Word address equals the issue count
  assign otp_addr_o  = iss_q[OtpAddrWidth-1:0];
  assign otp_wdata_o = otp_req_o ? data[iss_q[OtpAddrWidth-1:0]] : '0;

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      state_q <= ResetSt;
      error_q <= NoError;
    end else begin
      state_q <= state_d;
      error_q <= error_d;
    end
  end

  // Primary counters
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_cnt
    if (!rst_ni) begin
      iss_q <= '0;
      rsp_q <= '0;
    end else if (cnt_clr) begin
      iss_q <= '0;
      rsp_q <= '0;
    end else begin
      iss_q <= iss_q + LciCntWidth'(iss_inc);
      rsp_q <= rsp_q + LciCntWidth'(rsp_inc);
    end
  end

  // Shadow counters
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_cnt_dup
    if (!rst_ni) begin
      iss_dup_q <= '0;
      rsp_dup_q <= '0;
    end else if (cnt_clr) begin
      iss_dup_q <= '0;
      rsp_dup_q <= '0;
    end else begin
      iss_dup_q <= iss_dup_q + LciCntWidth'(iss_inc);
      rsp_dup_q <= rsp_dup_q + LciCntWidth'(rsp_inc);
    end
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  a_outputs_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({lc_ack_o, lc_err_o, error_o, fsm_err_o, lci_prog_idle_o,
                 otp_req_o, otp_cmd_o, otp_addr_o, otp_wdata_o}));

  // A response can only follow a granted word
  a_rsp_le_iss: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_q <= iss_q);

endmodule

`default_nettype wire

// ==== src/otp_rsp_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module otp_rsp_merge (
  input  wire logic                                clk_i,
  input  wire logic                                rst_ni,
  input  wire logic                                ord_push_i,
  input  wire logic [otp_lc_pkg::BankIdxWidth-1:0] ord_bank_i,
  input  wire logic [otp_lc_pkg::NumBanks-1:0]     rsp_valid_i,
  input  wire logic [otp_lc_pkg::NumBanks-1:0]     rsp_err_i,
  output logic                                     otp_rvalid_o,
  output otp_lc_pkg::otp_err_e                     otp_err_o
);
  import otp_lc_pkg::*;

  // Order queue of bank indices
  logic [BankIdxWidth-1:0]  ord_q [OrderDepth];
  logic [OrderPtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [OrderPtrWidth:0]   cnt_q;
  logic                     pop;
  logic [BankIdxWidth-1:0]  rsp_bank;

  // Locate the responding bank
  always_comb begin : p_sel
    rsp_bank = '0;
    for (int b = 0; b < NumBanks; b++) begin
      if (rsp_valid_i[b]) begin
        rsp_bank = BankIdxWidth'(b);
      end
    end
  end

  assign otp_rvalid_o = |rsp_valid_i;
  assign pop          = otp_rvalid_o && (cnt_q != '0);

  // Head mismatch or empty queue means out of order
  always_comb begin : p_err
    otp_err_o = NoError;
    if (otp_rvalid_o) begin
      if (cnt_q == '0 || rsp_bank != ord_q[rd_ptr_q]) begin
        otp_err_o = MacroOrderError;
      end else if (rsp_err_i[rsp_bank]) begin
        otp_err_o = MacroWriteBlankError;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ptr
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + OrderPtrWidth'(ord_push_i);
      rd_ptr_q <= rd_ptr_q + OrderPtrWidth'(pop);
      cnt_q    <= cnt_q + (OrderPtrWidth+1)'(ord_push_i) - (OrderPtrWidth+1)'(pop);
    end
  end

  always_ff @(posedge clk_i) begin : p_mem
    if (ord_push_i) begin
      ord_q[wr_ptr_q] <= ord_bank_i;
    end
  end

  a_one_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(rsp_valid_i));

  // Credits bound the outstanding words, so the queue never fills past depth
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(ord_push_i && !pop && cnt_q == (OrderPtrWidth+1)'(OrderDepth)));

endmodule

`default_nettype wire
